//--- pc_ibuf.f
src/pc_ibuf_pkg.sv
src/ibuf_if.sv
src/buf_bank_ctrl.sv
src/dwc_ram.sv
src/dec_ibuf.sv
src/llr_writer.sv
src/word_reader.sv
src/pc_ibuf_top.sv
verif/pc_ibuf_properties.sv
verif/tb_pc_ibuf.sv

//--- run.sh
#!/bin/sh
# build and run the pc_ibuf testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  --top-module tb_pc_ibuf -Mdir obj_dir -f pc_ibuf.f
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

./obj_dir/Vtb_pc_ibuf > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

# verdict comes from the log only
if grep -q "^all tests passed$" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- src/buf_bank_ctrl.sv
`timescale 1ns/1ps

module buf_bank_ctrl
  import pc_ibuf_pkg::*;
#(
  parameter int p_bnum_w = BNUM_W
) (
  input  logic                iclk,
  input  logic                rst_n,
  // write side closes a bank
  input  logic                wfull,
  // read side releases a bank
  input  logic                rempty,
  output logic [p_bnum_w-1:0] wbank,
  output logic [p_bnum_w-1:0] rbank,
  output logic                empty,
  output logic                full
);

  localparam int n_banks = 2 ** p_bnum_w;

  // one extra bit so all banks used is representable
  logic [p_bnum_w:0] used;
  logic [p_bnum_w:0] used_nxt;

  // ------------------------------
  // used bank count
  // ------------------------------

  always_comb begin
    case ({wfull, rempty})
      2'b10:   used_nxt = used + 1'b1;
      2'b01:   used_nxt = used - 1'b1;
      // both or neither, count holds
      default: used_nxt = used;
    endcase
  end

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      used  <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
    end else begin
      used  <= used_nxt;
      // flags follow the next count, no extra cycle
      empty <= (used_nxt == '0);
      full  <= (used_nxt == (p_bnum_w + 1)'(n_banks));
    end
  end

  // ------------------------------
  // ring pointers
  // ------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wbank <= '0;
      rbank <= '0;
    end else begin
      // pointers wrap on their own width
      if (wfull) begin
        wbank <= wbank + 1'b1;
      end
      if (rempty) begin
        rbank <= rbank + 1'b1;
      end
    end
  end

endmodule

//--- src/dec_ibuf.sv
`timescale 1ns/1ps

module dec_ibuf
  import pc_ibuf_pkg::*;
#(
  parameter int p_waddr_w = WADDR_W,
  parameter int p_raddr_w = RADDR_W,
  parameter int p_word_w  = WORD_W,
  parameter int p_bnum_w  = BNUM_W
) (
  input logic       iclk,
  input logic       rst_n,
  ibuf_wr_if.buffer wr,
  ibuf_rd_if.buffer rd
);

  // bank number sits above the in-block address
  localparam int ram_waddr_w = p_waddr_w + p_bnum_w;
  localparam int ram_raddr_w = p_raddr_w + p_bnum_w;

  logic [p_bnum_w-1:0] wbank;
  logic [p_bnum_w-1:0] rbank;

  // raw ram words, element per entry
  llr_t llr_word      [p_word_w];
  logic llr_frzb_word [p_word_w];
  logic frzb_word     [p_word_w];

  // one tag per bank
  tag_t tag_rf [2 ** p_bnum_w];

  // ------------------------------
  // bank ring
  // ------------------------------

  buf_bank_ctrl #(
    .p_bnum_w (p_bnum_w)
  ) u_bank_ctrl (
    .iclk   (iclk),
    .rst_n  (rst_n),
    .wfull  (wr.wfull),
    .rempty (rd.rempty),
    .wbank  (wbank),
    .rbank  (rbank),
    .empty  (rd.empty),
    .full   (wr.full)
  );

  // ------------------------------
  // llr and mask memories
  // ------------------------------

  // channel llrs at the natural index
  dwc_ram #(
    .elem_t    (llr_t),
    .p_waddr_w (ram_waddr_w),
    .p_raddr_w (ram_raddr_w),
    .p_word_w  (p_word_w)
  ) mem_llr (
    .iclk  (iclk),
    .write (wr.write),
    .waddr ({wbank, wr.llr_addr}),
    .wdat  (wr.llr),
    .raddr ({rbank, rd.raddr}),
    .rdat  (llr_word)
  );

  // re-encode mask, same order as the llrs
  dwc_ram #(
    .elem_t    (logic),
    .p_waddr_w (ram_waddr_w),
    .p_raddr_w (ram_raddr_w),
    .p_word_w  (p_word_w)
  ) mem_llr_frzb (
    .iclk  (iclk),
    .write (wr.write),
    .waddr ({wbank, wr.llr_addr}),
    .wdat  (wr.frzb),
    .raddr ({rbank, rd.raddr}),
    .rdat  (llr_frzb_word)
  );

  // decode mask, scattered to the bit-reversed index
  dwc_ram #(
    .elem_t    (logic),
    .p_waddr_w (ram_waddr_w),
    .p_raddr_w (ram_raddr_w),
    .p_word_w  (p_word_w)
  ) mem_frzb (
    .iclk  (iclk),
    .write (wr.write),
    .waddr ({wbank, wr.frzb_addr}),
    .wdat  (wr.frzb),
    .raddr ({rbank, rd.raddr}),
    .rdat  (frzb_word)
  );

  // element arrays into the packed read bus
  always_comb begin
    for (int i = 0; i < p_word_w; i++) begin
      rd.rllr[i]      = llr_word[i];
      rd.rllr_frzb[i] = llr_frzb_word[i];
      rd.rfrzb[i]     = frzb_word[i];
    end
  end

  // ------------------------------
  // tag register file
  // ------------------------------

  // captured as the bank closes
  always_ff @(posedge iclk) begin
    if (wr.wfull) begin
      tag_rf[wbank] <= wr.tag;
    end
  end

  assign rd.rtag = tag_rf[rbank];

endmodule

//--- src/dwc_ram.sv
`timescale 1ns/1ps

module dwc_ram
  import pc_ibuf_pkg::*;
#(
  parameter type elem_t    = logic,
  parameter int  p_waddr_w = WADDR_W,
  parameter int  p_raddr_w = RADDR_W,
  parameter int  p_word_w  = WORD_W
) (
  input  logic                 iclk,
  // element write port
  input  logic                 write,
  input  logic [p_waddr_w-1:0] waddr,
  input  elem_t                wdat,
  // word read port
  input  logic [p_raddr_w-1:0] raddr,
  output elem_t                rdat [p_word_w]
);

  // low address bits pick the element inside a word
  localparam int sel_w = p_waddr_w - p_raddr_w;

  elem_t mem [2 ** p_waddr_w];

  // ------------------------------
  // narrow write
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (write) begin
      mem[waddr] <= wdat;
    end
  end

  // ------------------------------
  // wide registered read
  // ------------------------------

  // element 0 at the lowest address of the word
  always_ff @(posedge iclk) begin
    for (int i = 0; i < p_word_w; i++) begin
      rdat[i] <= mem[{raddr, sel_w'(i)}];
    end
  end

endmodule

//--- src/ibuf_if.sv
`timescale 1ns/1ps

// writer to buffer, one sample per write strobe
interface ibuf_wr_if
  import pc_ibuf_pkg::*;
#(
  parameter int p_waddr_w = WADDR_W
) ();

  logic                 write;
  logic                 wfull;
  // natural index, llr and re-encode mask
  logic [p_waddr_w-1:0] llr_addr;
  // bit-reversed index, decode mask
  logic [p_waddr_w-1:0] frzb_addr;
  llr_t                 llr;
  logic                 frzb;
  tag_t                 tag;
  // all banks in use
  logic                 full;

  modport writer (
    output write, wfull, llr_addr, frzb_addr, llr, frzb, tag,
    input  full
  );

  modport buffer (
    input  write, wfull, llr_addr, frzb_addr, llr, frzb, tag,
    output full
  );

endinterface

// reader to buffer, word address out and wide word back
interface ibuf_rd_if
  import pc_ibuf_pkg::*;
#(
  parameter int p_raddr_w = RADDR_W,
  parameter int p_word_w  = WORD_W
) ();

  logic [p_raddr_w-1:0] raddr;
  // one cycle bank release
  logic                 rempty;
  llr_t [p_word_w-1:0]  rllr;
  logic [p_word_w-1:0]  rllr_frzb;
  logic [p_word_w-1:0]  rfrzb;
  tag_t                 rtag;
  logic                 empty;

  modport reader (
    output raddr, rempty,
    input  rllr, rllr_frzb, rfrzb, rtag, empty
  );

  modport buffer (
    input  raddr, rempty,
    output rllr, rllr_frzb, rfrzb, rtag, empty
  );

endinterface

//--- src/llr_writer.sv
`timescale 1ns/1ps

module llr_writer
  import pc_ibuf_pkg::*;
#(
  parameter int p_waddr_w = WADDR_W
) (
  input logic       iclk,
  input logic       rst_n,
  input logic       in_valid,
  input llr_t       in_llr,
  input logic       in_frozen,
  input tag_t       in_tag,
  ibuf_wr_if.writer wr
);

  // sample position inside the current block
  logic [p_waddr_w-1:0] cnt;
  logic [p_waddr_w-1:0] cnt_rev;
  logic                 first;
  logic                 last;

  // ------------------------------
  // address forming
  // ------------------------------

  // mirror the index bits for the decode mask
  always_comb begin
    for (int i = 0; i < p_waddr_w; i++) begin
      cnt_rev[i] = cnt[p_waddr_w-1-i];
    end
  end

  assign first = (cnt == '0);
  assign last  = &cnt;

  // ------------------------------
  // strobes and counter
  // ------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      wr.write <= 1'b0;
      wr.wfull <= 1'b0;
    end else begin
      wr.write <= in_valid;
      // block closes together with its last sample
      wr.wfull <= in_valid && last;
      if (in_valid) begin
        // wraps back to 0 after the last sample
        cnt <= cnt + 1'b1;
      end
    end
  end

  // registered sample stage
  always_ff @(posedge iclk) begin
    if (in_valid) begin
      wr.llr_addr  <= cnt;
      wr.frzb_addr <= cnt_rev;
      wr.llr       <= in_llr;
      wr.frzb      <= in_frozen;
      // tag held from first sample until wfull
      if (first) begin
        wr.tag <= in_tag;
      end
    end
  end

endmodule

//--- src/pc_ibuf_pkg.sv
package pc_ibuf_pkg;

  // ------------------------------
  // default sizes
  // ------------------------------

  // bits per channel llr
  localparam int LLR_W   = 4;
  // sample index within a block, 64 samples
  localparam int WADDR_W = 6;
  // llrs per engine word, also the mask width
  localparam int WORD_W  = 8;
  // word index within a block, 64 / 8 words
  localparam int RADDR_W = 3;
  // block tag width
  localparam int TAG_W   = 4;
  // bank pointer, ring of four banks
  localparam int BNUM_W  = 2;

  // ------------------------------
  // payload types
  // ------------------------------

  // signed channel llr
  typedef logic signed [LLR_W-1:0] llr_t;
  // tag that travels with each block
  typedef logic [TAG_W-1:0] tag_t;

endpackage

//--- src/pc_ibuf_top.sv
`timescale 1ns/1ps

module pc_ibuf_top
  import pc_ibuf_pkg::*;
#(
  parameter int p_waddr_w = WADDR_W,
  parameter int p_raddr_w = RADDR_W,
  parameter int p_word_w  = WORD_W,
  parameter int p_bnum_w  = BNUM_W
) (
  input  logic                iclk,
  input  logic                rst_n,
  // sample side
  input  logic                in_valid,
  input  llr_t                in_llr,
  input  logic                in_frozen,
  input  tag_t                in_tag,
  output logic                in_full,
  output logic                buf_empty,
  // engine side
  output logic                out_valid,
  output logic                out_sop,
  output logic                out_eop,
  output llr_t [p_word_w-1:0] out_llr,
  output logic [p_word_w-1:0] out_reenc_mask,
  output logic [p_word_w-1:0] out_dec_mask,
  output tag_t                out_tag
);

  ibuf_wr_if #(.p_waddr_w(p_waddr_w)) wr_if ();
  ibuf_rd_if #(.p_raddr_w(p_raddr_w), .p_word_w(p_word_w)) rd_if ();

  // ------------------------------
  // writer, buffer, reader
  // ------------------------------

  llr_writer #(
    .p_waddr_w (p_waddr_w)
  ) u_writer (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_llr    (in_llr),
    .in_frozen (in_frozen),
    .in_tag    (in_tag),
    .wr        (wr_if.writer)
  );

  dec_ibuf #(
    .p_waddr_w (p_waddr_w),
    .p_raddr_w (p_raddr_w),
    .p_word_w  (p_word_w),
    .p_bnum_w  (p_bnum_w)
  ) u_ibuf (
    .iclk  (iclk),
    .rst_n (rst_n),
    .wr    (wr_if.buffer),
    .rd    (rd_if.buffer)
  );

  word_reader #(
    .p_raddr_w (p_raddr_w),
    .p_word_w  (p_word_w)
  ) u_reader (
    .iclk           (iclk),
    .rst_n          (rst_n),
    .rd             (rd_if.reader),
    .out_valid      (out_valid),
    .out_sop        (out_sop),
    .out_eop        (out_eop),
    .out_llr        (out_llr),
    .out_reenc_mask (out_reenc_mask),
    .out_dec_mask   (out_dec_mask),
    .out_tag        (out_tag),
    .buf_empty      (buf_empty)
  );

  // source watches this before starting a block
  assign in_full = wr_if.full;

endmodule

//--- src/word_reader.sv
`timescale 1ns/1ps

module word_reader
  import pc_ibuf_pkg::*;
#(
  parameter int p_raddr_w = RADDR_W,
  parameter int p_word_w  = WORD_W
) (
  input  logic                iclk,
  input  logic                rst_n,
  ibuf_rd_if.reader           rd,
  output logic                out_valid,
  output logic                out_sop,
  output logic                out_eop,
  output llr_t [p_word_w-1:0] out_llr,
  output logic [p_word_w-1:0] out_reenc_mask,
  output logic [p_word_w-1:0] out_dec_mask,
  output tag_t                out_tag,
  output logic                buf_empty
);

  typedef enum logic {
    st_idle,
    st_read
  } state_t;

  state_t               state;
  logic [p_raddr_w-1:0] word_cnt;
  // an address goes out this cycle
  logic                 issue;
  logic                 last_word;

  // ------------------------------
  // word sequencer
  // ------------------------------

  // idle starts at once on a stored block, so word 0 has no wait
  assign issue     = (state == st_read) || !rd.empty;
  assign last_word = &word_cnt;

  assign rd.raddr  = word_cnt;
  // release bank with the final address
  assign rd.rempty = issue && last_word;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      word_cnt <= '0;
    end else if (issue) begin
      word_cnt <= word_cnt + 1'b1;
      // back to idle, which checks empty again
      state    <= last_word ? st_idle : st_read;
    end
  end

  // ------------------------------
  // output alignment
  // ------------------------------

  // flags delayed one cycle to meet the registered ram read
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_sop   <= 1'b0;
      out_eop   <= 1'b0;
    end else begin
      out_valid <= issue;
      out_sop   <= issue && (word_cnt == '0);
      out_eop   <= rd.rempty;
    end
  end

  // bank pointer moves before the last word leaves, so hold the tag here
  always_ff @(posedge iclk) begin
    if (issue) begin
      out_tag <= rd.rtag;
    end
  end

  // ram data straight through
  assign out_llr        = rd.rllr;
  assign out_reenc_mask = rd.rllr_frzb;
  assign out_dec_mask   = rd.rfrzb;
  assign buf_empty      = rd.empty;

endmodule

//--- verif/pc_ibuf_properties.sv
`timescale 1ns/1ps

module pc_ibuf_properties
  import pc_ibuf_pkg::*;
(
  input logic iclk,
  input logic rst_n,
  input logic in_valid,
  input logic in_full,
  input logic buf_empty,
  input logic out_valid,
  input logic out_sop,
  input logic out_eop
);

  // samples seen in the current input block
  logic [WADDR_W-1:0] smp_cnt;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      smp_cnt <= '0;
    end else if (in_valid) begin
      smp_cnt <= smp_cnt + 1'b1;
    end
  end

  // ------------------------------
  // input side
  // ------------------------------

  // no block may open on a full ring
  a_no_start_when_full: assert property (
    @(posedge iclk) disable iff (!rst_n)
    (in_valid && smp_cnt == '0) |-> !in_full
  ) else $error("block started while in_full was high");

  // ------------------------------
  // engine side, eight words per block
  // ------------------------------

  a_sop_to_eop: assert property (
    @(posedge iclk) disable iff (!rst_n)
    out_sop |-> ##7 (out_valid && out_eop)
  ) else $error("out_eop missing seven cycles after out_sop");

  // words of a block come back to back
  a_no_gap: assert property (
    @(posedge iclk) disable iff (!rst_n)
    (out_valid && !out_eop) |=> out_valid
  ) else $error("gap inside an output block");

  a_eop_after_sop: assert property (
    @(posedge iclk) disable iff (!rst_n)
    out_eop |-> $past(out_sop, 7)
  ) else $error("out_eop without out_sop seven cycles before");

  // a word needs a stored block or a read already running
  a_valid_needs_data: assert property (
    @(posedge iclk) disable iff (!rst_n)
    out_valid |-> (!$past(buf_empty) || ($past(out_valid) && !$past(out_eop)))
  ) else $error("out_valid while the buffer was empty");

endmodule

bind pc_ibuf_top pc_ibuf_properties u_props (
  .iclk      (iclk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_full   (in_full),
  .buf_empty (buf_empty),
  .out_valid (out_valid),
  .out_sop   (out_sop),
  .out_eop   (out_eop)
);

//--- verif/tb_pc_ibuf.sv
`timescale 1ns/1ps

module tb_pc_ibuf
  import pc_ibuf_pkg::*;
();

  localparam int n_samples = 2 ** WADDR_W;
  localparam int n_words   = 2 ** RADDR_W;
  localparam int n_banks   = 2 ** BNUM_W;
  localparam int max_wait  = 2000;

  typedef llr_t [WORD_W-1:0] llr_word_t;
  typedef logic [WORD_W-1:0] mask_t;

  logic      iclk;
  logic      rst_n;
  logic      in_valid;
  llr_t      in_llr;
  logic      in_frozen;
  tag_t      in_tag;
  logic      in_full;
  logic      buf_empty;
  logic      out_valid;
  logic      out_sop;
  logic      out_eop;
  llr_word_t out_llr;
  mask_t     out_reenc_mask;
  mask_t     out_dec_mask;
  tag_t      out_tag;

  // stimulus of the block being sent
  llr_t blk_llr [n_samples];
  logic blk_frz [n_samples];

  // expected engine words, oldest first
  llr_word_t exp_llr_q   [$];
  mask_t     exp_reenc_q [$];
  mask_t     exp_dec_q   [$];
  tag_t      exp_tag_q   [$];
  // blocks whose last word has not come out yet
  int        pending_blocks;
  int        word_idx;
  logic [16:0] lfsr;

  pc_ibuf_top dut (
    .iclk           (iclk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_llr         (in_llr),
    .in_frozen      (in_frozen),
    .in_tag         (in_tag),
    .in_full        (in_full),
    .buf_empty      (buf_empty),
    .out_valid      (out_valid),
    .out_sop        (out_sop),
    .out_eop        (out_eop),
    .out_llr        (out_llr),
    .out_reenc_mask (out_reenc_mask),
    .out_dec_mask   (out_dec_mask),
    .out_tag        (out_tag)
  );

  initial begin
    iclk = 1'b0;
    forever #50 iclk = ~iclk;
  end

  // ------------------------------
  // random bits and reference
  // ------------------------------

  // fibonacci lfsr x^17 + x^14 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[16] ^ lfsr[13];
    lfsr = {lfsr[15:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  // mirror of a sample index, its own inverse
  function automatic int bit_rev(input int idx);
    int r;
    r = 0;
    for (int b = 0; b < WADDR_W; b++) begin
      if (((idx >> b) & 1) != 0) begin
        r = r | (1 << (WADDR_W - 1 - b));
      end
    end
    return r;
  endfunction

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_llr(input string name, input llr_word_t exp, input llr_word_t act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_mask(input string name, input mask_t exp, input mask_t act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic fill_random();
    for (int i = 0; i < n_samples; i++) begin
      blk_llr[i] = llr_t'(rand_bits(LLR_W));
      blk_frz[i] = lfsr_bit();
    end
  endtask

  // word k holds samples 8k to 8k+7
  task automatic push_expected(input tag_t tag);
    llr_word_t w;
    mask_t     re;
    mask_t     de;
    for (int k = 0; k < n_words; k++) begin
      for (int j = 0; j < WORD_W; j++) begin
        w[j]  = blk_llr[k * WORD_W + j];
        re[j] = blk_frz[k * WORD_W + j];
        // decode slot p takes the sample whose reversed index is p
        de[j] = blk_frz[bit_rev(k * WORD_W + j)];
      end
      exp_llr_q.push_back(w);
      exp_reenc_q.push_back(re);
      exp_dec_q.push_back(de);
      exp_tag_q.push_back(tag);
    end
    pending_blocks++;
  endtask

  task automatic send_block(input tag_t tag, input logic use_gaps);
    int gap;
    int waited;
    waited = 0;
    // hold off while every bank is in use
    while (in_full) begin
      @(negedge iclk);
      in_valid = 1'b0;
      waited++;
      if (waited > max_wait) begin
        stop_on_failure("timeout waiting for in_full to fall");
      end
    end
    push_expected(tag);
    for (int i = 0; i < n_samples; i++) begin
      gap = use_gaps ? int'(rand_bits(2)) : 0;
      repeat (gap) begin
        @(negedge iclk);
        in_valid = 1'b0;
      end
      @(negedge iclk);
      in_valid  = 1'b1;
      in_llr    = blk_llr[i];
      in_frozen = blk_frz[i];
      // only the first sample's tag should stick
      in_tag    = (i == 0) ? tag : ~tag;
    end
  endtask

  task automatic idle_input();
    @(negedge iclk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pending_blocks != 0) begin
      @(negedge iclk);
      cycles++;
      if (cycles > max_wait) begin
        stop_on_failure("timeout waiting for all blocks to come out");
      end
    end
  endtask

  // ------------------------------
  // output checker
  // ------------------------------

  initial begin
    forever begin
      @(negedge iclk);
      if (in_full && pending_blocks < n_banks) begin
        stop_on_failure("in_full high with fewer than four blocks stored");
      end
      if (rst_n && out_valid) begin
        if (exp_llr_q.size() == 0) begin
          stop_on_failure("out_valid with no block expected");
        end
        check_flag("out_sop", word_idx == 0, out_sop);
        check_flag("out_eop", word_idx == n_words - 1, out_eop);
        check_llr("out_llr", exp_llr_q.pop_front(), out_llr);
        check_mask("out_reenc_mask", exp_reenc_q.pop_front(), out_reenc_mask);
        check_mask("out_dec_mask", exp_dec_q.pop_front(), out_dec_mask);
        check_tag("out_tag", exp_tag_q.pop_front(), out_tag);
        if (word_idx == n_words - 1) begin
          word_idx = 0;
          pending_blocks--;
        end else begin
          word_idx++;
        end
      end else begin
        check_flag("out_sop", 1'b0, out_sop);
        check_flag("out_eop", 1'b0, out_eop);
      end
    end
  end

  // ------------------------------
  // tests
  // ------------------------------

  task automatic test_reset_state();
    check_flag("buf_empty", 1'b1, buf_empty);
    check_flag("in_full", 1'b0, in_full);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("out_sop", 1'b0, out_sop);
    check_flag("out_eop", 1'b0, out_eop);
  endtask

  task automatic test_single_block();
    int cycles;
    fill_random();
    send_block(tag_t'(rand_bits(TAG_W)), 1'b0);
    // falling edges from the last sample to the first word
    cycles = 0;
    do begin
      @(negedge iclk);
      in_valid = 1'b0;
      cycles++;
      if (cycles > max_wait) begin
        stop_on_failure("timeout waiting for the first out_valid");
      end
    end while (!out_valid);
    if (cycles != 3) begin
      stop_on_failure($sformatf("[ERROR] out_valid latency expected %h got %h", 3, cycles));
    end
    wait_drained();
  endtask

  // frozen only at 1 2 and 4
  // their mirrors 32 16 and 8 sit in other words
  task automatic test_bitrev_mask();
    for (int i = 0; i < n_samples; i++) begin
      blk_llr[i] = llr_t'(rand_bits(LLR_W));
      blk_frz[i] = (i != 0) && (i < WORD_W) && ((i & (i - 1)) == 0);
    end
    send_block(4'ha, 1'b0);
    idle_input();
    wait_drained();
  endtask

  task automatic test_fill_banks();
    for (int b = 0; b < n_banks; b++) begin
      fill_random();
      send_block(tag_t'(b * 3 + 1), 1'b0);
    end
    idle_input();
    wait_drained();
  endtask

  task automatic test_streaming();
    for (int b = 0; b < 10; b++) begin
      fill_random();
      send_block(tag_t'(rand_bits(TAG_W)), 1'b1);
    end
    idle_input();
    wait_drained();
    check_flag("buf_empty", 1'b1, buf_empty);
  endtask

  initial begin
    lfsr           = 17'd93463;
    pending_blocks = 0;
    word_idx       = 0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_llr         = '0;
    in_frozen      = 1'b0;
    in_tag         = '0;
    repeat (5) @(negedge iclk);
    rst_n = 1'b1;
    @(negedge iclk);
    test_reset_state();
    test_single_block();
    test_bitrev_mask();
    test_fill_banks();
    test_streaming();
    $display("all tests passed");
    $finish;
  end

endmodule
